// ==== compile.f ====
hdl/mania_pkg.sv
hdl/chart_ram.sv
hdl/chart_loader.sv
hdl/lane_table_scan.sv
hdl/playback_timer.sv
hdl/core_sequencer.sv
hdl/mania_core.sv
test/mania_core_assert.sv
test/tb_mania_core.sv

// ==== hdl/chart_loader.sv ====
////////////////////////////////////////
// receives chart bytes over req/ack and packs
// them lsb first into words for chart memory
////////////////////////////////////////

`timescale 1ns/1ps

module chart_loader import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	input logic load_start,
	output logic chart_req,
	input logic chart_ack,
	input byte_xfer_t chart_byte,
	output logic wr_en,
	output logic [ADDR_W-1:0] wr_addr,
	output logic [WORD_W-1:0] wr_data,
	output logic load_done
);

	typedef enum logic [1:0] {LD_IDLE, LD_REQ, LD_REL} ld_state_e;

	ld_state_e st;
	logic [$clog2(BYTES_PER_WORD)-1:0] byte_cnt;
	logic [WORD_W-1:0] word;
	logic [WORD_W-1:0] merged;
	logic [ADDR_W-1:0] word_idx;
	logic take;
	logic word_end;
	logic fin;

	assign take = (st == LD_REQ) && chart_ack;
	assign word_end = (byte_cnt == BYTES_PER_WORD - 1) || chart_byte.last;
	assign merged = word | (WORD_W'(chart_byte.data) << (BYTE_W * byte_cnt));
	assign chart_req = (st == LD_REQ);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			st <= LD_IDLE;
			byte_cnt <= '0;
			word_idx <= '0;
			wr_en <= 1'b0;
			fin <= 1'b0;
			load_done <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			fin <= 1'b0;
			load_done <= fin; // one cycle after the last write
			case (st)
				LD_IDLE: if (load_start) begin
					st <= LD_REQ;
					byte_cnt <= '0;
					word_idx <= '0;
				end
				LD_REQ: if (chart_ack) begin
					st <= chart_byte.last ? LD_IDLE : LD_REL; // no more req after last
					fin <= chart_byte.last;
					if (word_end) begin
						wr_en <= 1'b1;
						word_idx <= word_idx + 1'b1;
						byte_cnt <= '0;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				LD_REL: if (!chart_ack)
					st <= LD_REQ;
				default: st <= LD_IDLE;
			endcase
		end
	end

	// word assembler
	always_ff @(posedge CLK) begin
		if (st == LD_IDLE && load_start) begin
			word <= '0;
		end else if (take) begin
			if (word_end) begin
				word <= '0; // missing high bytes stay zero
				wr_data <= merged;
				wr_addr <= word_idx;
			end else begin
				word <= merged;
			end
		end
	end

endmodule

// ==== hdl/chart_ram.sv ====
////////////////////////////////////////
// on-chip chart memory
// one write port, one registered read port
////////////////////////////////////////

`timescale 1ns/1ps

module chart_ram import mania_pkg::*; (
	input logic CLK,
	input logic wr_en,
	input logic [ADDR_W-1:0] wr_addr,
	input logic [WORD_W-1:0] wr_data,
	input logic rd_en,
	input logic [ADDR_W-1:0] rd_addr,
	output logic [WORD_W-1:0] rd_data
);

	logic [WORD_W-1:0] mem [CHART_DEPTH];

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read data holds while rd_en is low
	always_ff @(posedge CLK) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

// ==== hdl/core_sequencer.sv ====
////////////////////////////////////////
// phase register for load, scan and play
// decodes engine start pulses from the phase
////////////////////////////////////////

`timescale 1ns/1ps

module core_sequencer import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	output core_phase_e phase,
	output logic load_start,
	input logic load_done,
	output logic scan_start,
	input logic scan_done,
	output logic play_en
);

	core_phase_e phase_nx;

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			phase <= PH_INIT;
		else
			phase <= phase_nx;
	end

	always_comb begin
		phase_nx = phase;
		case (phase)
			PH_INIT:
				phase_nx = PH_LOAD;
			PH_LOAD:
				phase_nx = PH_W_LOAD;
			PH_W_LOAD:
				if (load_done)
					phase_nx = PH_SCAN;
			PH_SCAN:
				phase_nx = PH_W_SCAN;
			PH_W_SCAN:
				if (scan_done)
					phase_nx = PH_PLAY;
			PH_PLAY:
				phase_nx = PH_PLAY; // stays until reset
			default:
				phase_nx = PH_INIT;
		endcase
	end

	// single cycle starts, the load/scan phases last one clock
	assign load_start = (phase == PH_LOAD);
	assign scan_start = (phase == PH_SCAN);
	assign play_en = (phase == PH_PLAY);

endmodule

// ==== hdl/lane_table_scan.sv ====
////////////////////////////////////////
// walks the lane size table at the head of the
// chart and holds base/size for each lane
////////////////////////////////////////

`timescale 1ns/1ps

module lane_table_scan import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	input logic scan_start,
	output logic rd_en,
	output logic [ADDR_W-1:0] rd_addr,
	input logic [WORD_W-1:0] rd_data,
	output lane_table_t lane_table,
	output logic scan_done
);

	typedef enum logic [1:0] {SC_IDLE, SC_ADDR, SC_WAIT, SC_CAP} sc_state_e;

	sc_state_e st;
	logic [$clog2(LANES)-1:0] lane;
	logic [ADDR_W-1:0] rd_ptr; // address of the current size word
	logic [ADDR_W-1:0] size_w;

	assign size_w = rd_data[ADDR_W-1:0];
	assign rd_en = (st == SC_ADDR);
	assign rd_addr = rd_ptr;

	// last capture, phase moves on at the same edge
	assign scan_done = (st == SC_CAP) && (lane == LANES - 1);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			st <= SC_IDLE;
			lane <= '0;
			rd_ptr <= '0;
			lane_table <= '0;
		end else begin
			case (st)
				SC_IDLE: if (scan_start) begin
					st <= SC_ADDR;
					lane <= '0;
					rd_ptr <= '0;
				end
				SC_ADDR: st <= SC_WAIT;
				SC_WAIT: st <= SC_CAP; // read data lands here
				SC_CAP: begin
					lane_table[lane].base <= rd_ptr + 1'b1;
					lane_table[lane].size <= size_w;
					// next lane reads at base + size
					rd_ptr <= rd_ptr + 1'b1 + size_w;
					lane <= lane + 1'b1;
					if (lane == LANES - 1)
						st <= SC_IDLE;
					else
						st <= SC_ADDR;
				end
				default: st <= SC_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/mania_core.sv ====
////////////////////////////////////////
// rhythm game core top level
// load chart, scan lane table, then play
////////////////////////////////////////

`timescale 1ns/1ps

module mania_core import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	output logic chart_req,
	input logic chart_ack,
	input byte_xfer_t chart_byte,
	output logic song_req,
	input logic song_ack,
	input logic [BYTE_W-1:0] song_sample,
	output core_phase_e phase,
	output lane_table_t lane_table,
	output logic update_tick,
	output logic audio_en,
	output logic [BYTE_W-1:0] audio_out
);

	logic load_start;
	logic load_done;
	logic scan_start;
	logic scan_done;
	logic play_en;

	// chart memory ports
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [WORD_W-1:0] wr_data;
	logic rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic [WORD_W-1:0] rd_data;

	core_sequencer u_seq (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.phase(phase),
		.load_start(load_start),
		.load_done(load_done),
		.scan_start(scan_start),
		.scan_done(scan_done),
		.play_en(play_en)
	);

	chart_loader u_loader (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.load_start(load_start),
		.chart_req(chart_req),
		.chart_ack(chart_ack),
		.chart_byte(chart_byte),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.load_done(load_done)
	);

	chart_ram u_ram (
		.CLK(CLK),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	lane_table_scan u_scan (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.scan_start(scan_start),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.lane_table(lane_table),
		.scan_done(scan_done)
	);

	playback_timer u_play (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.play_en(play_en),
		.update_tick(update_tick),
		.audio_en(audio_en),
		.song_req(song_req),
		.song_ack(song_ack),
		.song_sample(song_sample),
		.audio_out(audio_out)
	);

endmodule

// ==== hdl/mania_pkg.sv ====
////////////////////////////////////////
// shared sizes, tick periods and types for the rhythm game core
// import into every core module
////////////////////////////////////////

package mania_pkg;

	// chart source and memory
	localparam int BYTE_W = 8;
	localparam int BYTES_PER_WORD = 3;
	localparam int WORD_W = BYTE_W * BYTES_PER_WORD;
	localparam int ADDR_W = 13;
	localparam int CHART_DEPTH = 8192;
	localparam int LANES = 4;

	// play timing, short for simulation
	localparam int AUDIO_PERIOD = 8; // clocks per audio tick
	localparam int UPDATE_PERIOD = 20; // clocks per update tick
	localparam int PLAY_DELAY = 4; // silent audio ticks

	typedef enum logic [2:0] {
		PH_INIT,
		PH_LOAD,
		PH_W_LOAD,
		PH_SCAN,
		PH_W_SCAN,
		PH_PLAY
	} core_phase_e;

	// one byte from the chart source
	typedef struct packed {
		logic [BYTE_W-1:0] data;
		logic last; // final chart byte
	} byte_xfer_t;

	typedef struct packed {
		logic [ADDR_W-1:0] base;
		logic [ADDR_W-1:0] size;
	} lane_entry_t;

	typedef lane_entry_t [LANES-1:0] lane_table_t;

endpackage

// ==== hdl/playback_timer.sv ====
////////////////////////////////////////
// audio and update ticks in play, start delay,
// and the req/ack fetch of song samples
////////////////////////////////////////

`timescale 1ns/1ps

module playback_timer import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	input logic play_en,
	output logic update_tick,
	output logic audio_en,
	output logic song_req,
	input logic song_ack,
	input logic [BYTE_W-1:0] song_sample,
	output logic [BYTE_W-1:0] audio_out
);

	typedef enum logic [1:0] {SG_IDLE, SG_REQ, SG_REL} sg_state_e;

	sg_state_e sst;
	logic [$clog2(AUDIO_PERIOD)-1:0] audio_cnt;
	logic [$clog2(UPDATE_PERIOD)-1:0] update_cnt;
	logic [$clog2(PLAY_DELAY+1)-1:0] delay_cnt;
	logic audio_tick;

	assign audio_tick = play_en && (audio_cnt == AUDIO_PERIOD - 1);
	assign audio_en = play_en;
	assign song_req = (sst == SG_REQ);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			audio_cnt <= '0;
			update_cnt <= '0;
			update_tick <= 1'b0;
		end else if (!play_en) begin
			audio_cnt <= '0;
			update_cnt <= '0;
			update_tick <= 1'b0;
		end else begin
			audio_cnt <= audio_tick ? '0 : audio_cnt + 1'b1;
			update_cnt <= (update_cnt == UPDATE_PERIOD - 1) ? '0 : update_cnt + 1'b1;
			update_tick <= (update_cnt == UPDATE_PERIOD - 1);
		end
	end

	// ticks during an open fetch are simply lost
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			sst <= SG_IDLE;
			delay_cnt <= '0;
		end else begin
			if (audio_tick && delay_cnt < PLAY_DELAY)
				delay_cnt <= delay_cnt + 1'b1;
			case (sst)
				SG_IDLE: if (audio_tick && delay_cnt == PLAY_DELAY)
					sst <= SG_REQ;
				SG_REQ: if (song_ack)
					sst <= SG_REL;
				SG_REL: if (!song_ack)
					sst <= SG_IDLE;
				default: sst <= SG_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (sst == SG_REQ && song_ack)
			audio_out <= song_sample;
	end

endmodule

// ==== test/mania_core_assert.sv ====
////////////////////////////////////////
// req/ack and pulse rules for the core
// bound to chart_loader and playback_timer
////////////////////////////////////////

`timescale 1ns/1ps

module mania_core_assert (
	input logic CLK,
	input logic RESET_L,
	input logic req,
	input logic ack,
	input logic req_allowed,
	input logic done
);

	// req waits for ack
	a_req_hold: assert property (@(posedge CLK) disable iff (!RESET_L)
		req && !ack |=> req)
		else $error("req dropped before ack was seen");

	a_req_rise: assert property (@(posedge CLK) disable iff (!RESET_L)
		!req && ack |=> !req)
		else $error("req raised while ack still high");

	a_req_gate: assert property (@(posedge CLK) disable iff (!RESET_L)
		req |-> req_allowed)
		else $error("req raised outside its enable");

	a_done_pulse: assert property (@(posedge CLK) disable iff (!RESET_L)
		done |=> !done)
		else $error("done held longer than one cycle");

endmodule

bind chart_loader mania_core_assert u_assert (
	.CLK(CLK),
	.RESET_L(RESET_L),
	.req(chart_req),
	.ack(chart_ack),
	.req_allowed(!load_done), // no request once the last byte is in
	.done(load_done)
);

bind playback_timer mania_core_assert u_assert (
	.CLK(CLK),
	.RESET_L(RESET_L),
	.req(song_req),
	.ack(song_ack),
	.req_allowed(play_en),
	.done(update_tick)
);

// ==== test/tb_mania_core.sv ====
////////////////////////////////////////
// testbench for the rhythm game core
// serves chart bytes and song samples over req/ack
// and checks phases, lane table, ticks and audio
////////////////////////////////////////

`timescale 1ns/1ps

module tb_mania_core import mania_pkg::*; ();

	localparam int NWORDS = 12;
	localparam int NBYTES = 35; // last word only two bytes
	localparam int NSAMP = 6;
	localparam int TIMEOUT_CYC = NBYTES * 14 + 12 + UPDATE_PERIOD * 10
		+ AUDIO_PERIOD * (PLAY_DELAY + NSAMP) * 2 + 200;

	logic CLK;
	logic RESET_L;
	logic chart_req;
	logic chart_ack;
	byte_xfer_t chart_byte;
	logic song_req;
	logic song_ack;
	logic [BYTE_W-1:0] song_sample;
	core_phase_e phase;
	lane_table_t lane_table;
	logic update_tick;
	logic audio_en;
	logic [BYTE_W-1:0] audio_out;

	// size words carry junk above the low ADDR_W bits
	logic [WORD_W-1:0] chart_words [NWORDS] = '{
		24'h5A0002, 24'h00A101, 24'h00A102,
		24'h3C0001, 24'h00B101,
		24'h000003, 24'h00C101, 24'h00C102, 24'h00C103,
		24'hE00002, 24'h00D101, 24'h00D102
	};
	// base = size address + 1, next size address = base + size
	lane_entry_t exp_lanes [LANES] = '{
		'{13'd1, 13'd2}, '{13'd4, 13'd1}, '{13'd6, 13'd3}, '{13'd10, 13'd2}
	};
	logic [BYTE_W-1:0] samples [NSAMP] = '{8'h3F, 8'hC4, 8'h07, 8'h9A, 8'h51, 8'hE8};
	core_phase_e order [6] = '{PH_INIT, PH_LOAD, PH_W_LOAD, PH_SCAN, PH_W_SCAN, PH_PLAY};

	logic [31:0] rng_state = 32'd85;
	int cycle_cnt = 0;
	int fail_cnt = 0;

	mania_core UUT (.*);

	always #10 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYC) begin
			$display("timeout after %0d cycles, the run did not finish", cycle_cnt);
			end_with_failure();
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int next_wait();
		rng_state = xorshift32(rng_state);
		return rng_state % 6;
	endfunction

	task automatic wait_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic end_with_failure();
		fail_cnt++;
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_lane(input lane_entry_t act, input lane_entry_t exp, input int idx);
		if (act !== exp) begin
			$display("FAILED at %0t: lane_table[%0d] expected base %0d size %0d, got base %0d size %0d",
				$time, idx, exp.base, exp.size, act.base, act.size);
			end_with_failure();
		end
	endtask

	task automatic check_phase(input core_phase_e act, input core_phase_e exp);
		if (act !== exp) begin
			$display("FAILED at %0t: phase expected %s, got %s", $time, exp.name(), act.name());
			end_with_failure();
		end
	endtask

	task automatic check_sample(input logic [BYTE_W-1:0] act, input logic [BYTE_W-1:0] exp);
		if (act !== exp) begin
			$display("FAILED at %0t: audio_out expected %h, got %h", $time, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_bit(input logic act, input logic exp, input string name);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
			end_with_failure();
		end
	endtask

	// bytes go out lsb first, one per handshake
	task automatic serve_chart();
		int n;
		for (int i = 0; i < NBYTES; i++) begin
			while (!chart_req)
				wait_cycle();
			n = next_wait();
			repeat (n) wait_cycle();
			chart_byte.data = chart_words[i / 3] >> (BYTE_W * (i % 3));
			chart_byte.last = (i == NBYTES - 1);
			chart_ack = 1'b1;
			while (chart_req)
				wait_cycle();
			chart_ack = 1'b0;
		end
	endtask

	task automatic serve_song();
		int n;
		for (int i = 0; i < NSAMP; i++) begin
			while (!song_req)
				wait_cycle();
			n = next_wait();
			repeat (n) wait_cycle();
			song_sample = samples[i];
			song_ack = 1'b1;
			while (song_req)
				wait_cycle();
			song_ack = 1'b0;
		end
	endtask

	task automatic watch_ticks();
		int cyc;
		logic hit;
		for (int k = 0; k < 4; k++) begin
			cyc = 0;
			hit = 1'b0;
			while (!hit && cyc <= UPDATE_PERIOD) begin
				wait_cycle();
				cyc++;
				check_bit(audio_en, 1'b1, "audio_en");
				hit = update_tick;
			end
			if (!hit || cyc != UPDATE_PERIOD) begin
				$display("update tick %0d came after %0d cycles instead of %0d", k, cyc,
					UPDATE_PERIOD);
				end_with_failure();
			end
		end
	endtask

	task automatic watch_audio();
		int cyc;
		cyc = 0;
		while (!song_req) begin
			wait_cycle();
			cyc++;
		end
		// fifth audio tick is the first that fetches
		if (cyc != AUDIO_PERIOD * (PLAY_DELAY + 1)) begin
			$display("first song request came %0d cycles into play, expected %0d", cyc,
				AUDIO_PERIOD * (PLAY_DELAY + 1));
			end_with_failure();
		end
		for (int s = 0; s < NSAMP; s++) begin
			while (!song_req)
				wait_cycle();
			while (song_req)
				wait_cycle();
			check_sample(audio_out, samples[s]);
		end
	endtask

	initial begin
		int idx;
		int held;
		CLK = 1'b0;
		RESET_L = 1'b0;
		chart_ack = 1'b0;
		chart_byte = '0;
		song_ack = 1'b0;
		song_sample = '0;
		repeat (10) @(posedge CLK);
		#1;
		check_bit(chart_req, 1'b0, "chart_req");
		check_bit(song_req, 1'b0, "song_req");
		check_bit(update_tick, 1'b0, "update_tick");
		check_bit(audio_en, 1'b0, "audio_en");
		check_phase(phase, PH_INIT);
		RESET_L = 1'b1;
		fork
			serve_chart();
			serve_song();
		join_none
		idx = 0;
		held = 0;
		while (order[idx] != PH_PLAY) begin
			wait_cycle();
			held++;
			if (phase != order[idx]) begin
				check_phase(phase, order[idx + 1]);
				if ((order[idx] == PH_LOAD || order[idx] == PH_SCAN) && held != 1) begin
					$display("phase %s lasted %0d cycles, not one", order[idx].name(), held);
					end_with_failure();
				end
				if (order[idx] == PH_W_SCAN && held != 12) begin
					$display("lane scan took %0d cycles instead of 12", held);
					end_with_failure();
				end
				idx++;
				held = 0;
			end
		end
		for (int l = 0; l < LANES; l++)
			check_lane(lane_table[l], exp_lanes[l], l);
		fork
			watch_ticks();
			watch_audio();
		join
		if (fail_cnt == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			end_with_failure();
		end
	end

endmodule
